/* xbuf_pkg.sv */
// Operand staging shared definitions
`default_nettype none

package xbuf_pkg;

  // Element and array sizing
  localparam int unsigned BITW      = 16;
  localparam int unsigned H         = 4;
  localparam int unsigned W         = 4;
  localparam int unsigned D         = 2;
  localparam int unsigned TOT_DEPTH = H * D;
  localparam int unsigned DW        = TOT_DEPTH * BITW;

  // Counter and pointer widths derived from the array shape
  localparam int unsigned CNT_W  = $clog2(TOT_DEPTH + 1);
  localparam int unsigned COL_W  = $clog2(TOT_DEPTH);
  localparam int unsigned LINE_W = $clog2(W);
  localparam int unsigned WIDX_W = $clog2(W + 1);
  localparam int unsigned PTR_W  = $clog2(H) + 1;
  localparam int unsigned OCC_W  = $clog2(2 * H + 1);

  // APB bus geometry
  localparam int unsigned APB_AW = 32;
  localparam int unsigned APB_DW = 32;

  // Register map
  localparam logic [APB_AW-1:0] REG_CFG    = 32'h0;
  localparam logic [APB_AW-1:0] REG_CMD    = 32'h4;
  localparam logic [APB_AW-1:0] REG_STATUS = 32'h8;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    FILL,
    DRAIN,
    DONE
  } xbuf_state_e;

endpackage

`default_nettype wire

/* xbuf_pad_mem.sv */
// Operand pad memory
`timescale 1ns/10ps
`default_nettype none

module xbuf_pad_mem
  import xbuf_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         wr_en_i,
  input  logic [LINE_W-1:0]            wr_line_i,
  input  logic [DW-1:0]                wdata_i,
  input  logic                         rd_en_i,
  input  logic [COL_W-1:0]             rd_col_i,
  output logic [W-1:0][BITW-1:0]       rdata_o
);

  // Each line holds one streamed row of TOT_DEPTH elements
  logic [W-1:0][TOT_DEPTH-1:0][BITW-1:0] mem_q;
  logic [W-1:0][BITW-1:0]                rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (clear_i) begin
      mem_q <= '0;
    end else if (wr_en_i) begin
      mem_q[wr_line_i] <= wdata_i;
    end
  end

  // A column read picks the same element out of every line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_en_i) begin
      for (int w = 0; w < W; w++) begin
        rdata_q[w] <= mem_q[w][rd_col_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* xbuf_row_buffer.sv */
// Two-bank column buffer
`timescale 1ns/10ps
`default_nettype none

module xbuf_row_buffer
  import xbuf_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          wr_en_i,
  input  logic [PTR_W-1:0]              wr_slot_i,
  input  logic [W-1:0][BITW-1:0]        wdata_i,
  input  logic                          rd_bank_i,
  output logic [W-1:0][H-1:0][BITW-1:0] rdata_o
);

  // Slot storage indexed by bank, then column slot, then element
  logic [1:0][H-1:0][W-1:0][BITW-1:0] slot_q;

  logic            wr_bank;
  logic [PTR_W-2:0] wr_idx;

  // Top bit of the slot address selects the bank
  assign wr_bank = wr_slot_i[PTR_W-1];
  assign wr_idx  = wr_slot_i[PTR_W-2:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q <= '0;
    end else if (clear_i) begin
      slot_q <= '0;
    end else if (wr_en_i) begin
      slot_q[wr_bank][wr_idx] <= wdata_i;
    end
  end

  // The consumer sees the selected bank transposed to W by H
  always_comb begin
    for (int w = 0; w < W; w++) begin
      for (int h = 0; h < H; h++) begin
        rdata_o[w][h] = slot_q[rd_bank_i][h][w];
      end
    end
  end

endmodule

`default_nettype wire

/* xbuf_ctrl.sv */
// Operand staging controller
`timescale 1ns/10ps
`default_nettype none

module xbuf_ctrl
  import xbuf_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              pad_setup_i,
  input  logic              rst_w_index_i,
  input  logic [WIDX_W-1:0] cfg_width_i,
  input  logic [CNT_W-1:0]  cfg_height_i,
  input  logic [CNT_W-1:0]  cfg_slots_i,
  input  logic              x_load_i,
  input  logic              h_shift_i,
  output logic              pad_wr_en_o,
  output logic [LINE_W-1:0] pad_wr_line_o,
  output logic              pad_rd_en_o,
  output logic [COL_W-1:0]  pad_rd_col_o,
  output logic              buf_wr_en_o,
  output logic [PTR_W-1:0]  buf_wr_slot_o,
  output logic              buf_wr_zero_o,
  output logic              buf_rd_bank_o,
  output logic              x_valid_o,
  output logic              full_o,
  output logic              empty_o
);

  xbuf_state_e state_q, state_d;

  logic [WIDX_W-1:0] line_q;
  logic [CNT_W-1:0]  rd_col_q;
  logic [CNT_W-1:0]  ret_col_q;
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [OCC_W-1:0]  occ_q;
  logic [OCC_W-1:0]  wr_cnt_q;
  logic              rd_pend_q;
  logic              zero_q;

  logic start;
  logic rd_issue;
  logic shift_acc;
  logic bank_flip;

  // A new block starts only from IDLE or DONE
  assign start = pad_setup_i && (state_q == IDLE || state_q == DONE);

  // Slots are reserved at read time, so the in-flight column already counts
  assign rd_issue = (state_q == FILL) && (rd_col_q < cfg_slots_i) &&
                    (occ_q < OCC_W'(2 * H));

  assign x_valid_o = wr_cnt_q >= OCC_W'(H);
  assign shift_acc = h_shift_i && x_valid_o;
  assign bank_flip = shift_acc && (rd_ptr_q[PTR_W-2:0] == (PTR_W-1)'(H - 1));
  assign empty_o   = shift_acc && (ret_col_q == cfg_slots_i - 1'b1);

  // An unprogrammed width of zero never reports full
  assign full_o    = (cfg_width_i != '0) && (line_q == cfg_width_i);

  assign pad_wr_en_o   = x_load_i;
  assign pad_wr_line_o = line_q[LINE_W-1:0];
  assign pad_rd_en_o   = rd_issue;
  assign pad_rd_col_o  = rd_col_q[COL_W-1:0];
  assign buf_wr_en_o   = rd_pend_q;
  assign buf_wr_slot_o = wr_ptr_q;
  assign buf_wr_zero_o = zero_q;
  assign buf_rd_bank_o = rd_ptr_q[PTR_W-1];

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start) state_d = FILL;
      FILL:    if (rd_col_q >= cfg_slots_i) state_d = DRAIN;
      DRAIN:   if (empty_o) state_d = DONE;
      DONE:    if (start) state_d = FILL;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Line index counts loaded rows until software acknowledges full
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_q <= '0;
    end else if (clear_i || rst_w_index_i) begin
      line_q <= '0;
    end else if (x_load_i) begin
      line_q <= line_q + 1'b1;
    end
  end

  // Column counters for the read side and the retire side of a block
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_col_q  <= '0;
      ret_col_q <= '0;
    end else if (clear_i || start) begin
      rd_col_q  <= '0;
      ret_col_q <= '0;
    end else begin
      if (rd_issue) begin
        rd_col_q <= rd_col_q + 1'b1;
      end
      if (shift_acc) begin
        ret_col_q <= ret_col_q + 1'b1;
      end
    end
  end

  // The zero mark travels alongside the pad read latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pend_q <= 1'b0;
      zero_q    <= 1'b0;
    end else if (clear_i) begin
      rd_pend_q <= 1'b0;
      zero_q    <= 1'b0;
    end else begin
      rd_pend_q <= rd_issue;
      zero_q    <= rd_issue && (rd_col_q >= cfg_height_i);
    end
  end

  // Pointers wrap over both banks, so the top bit is the bank
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (rd_pend_q) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (shift_acc) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Slots come back a whole bank at a time, which keeps writes away
  // from the bank the consumer is looking at
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occ_q    <= '0;
      wr_cnt_q <= '0;
    end else if (clear_i) begin
      occ_q    <= '0;
      wr_cnt_q <= '0;
    end else begin
      occ_q    <= occ_q + OCC_W'(rd_issue) - (bank_flip ? OCC_W'(H) : '0);
      wr_cnt_q <= wr_cnt_q + OCC_W'(rd_pend_q) - (bank_flip ? OCC_W'(H) : '0);
    end
  end

endmodule

`default_nettype wire

/* xbuf_regs.sv */
// Operand staging register block
`timescale 1ns/10ps
`default_nettype none

module xbuf_regs
  import xbuf_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic [APB_AW-1:0] paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [APB_DW-1:0] pwdata_i,
  output logic [APB_DW-1:0] prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  input  logic              full_i,
  input  logic              empty_i,
  input  logic              x_valid_i,
  output logic [WIDX_W-1:0] cfg_width_o,
  output logic [CNT_W-1:0]  cfg_height_o,
  output logic [CNT_W-1:0]  cfg_slots_o,
  output logic              clear_o,
  output logic              pad_setup_o,
  output logic              rst_w_index_o
);

  logic access;
  logic wr_cfg;
  logic wr_cmd;
  logic known;
  logic empty_seen_q;

  assign access = psel_i && penable_i;
  assign wr_cfg = access && pwrite_i && (paddr_i == REG_CFG);
  assign wr_cmd = access && pwrite_i && (paddr_i == REG_CMD);
  assign known  = (paddr_i == REG_CFG) || (paddr_i == REG_CMD) ||
                  (paddr_i == REG_STATUS);

  // No wait states on this slave
  assign pready_o  = 1'b1;
  assign pslverr_o = access && (!known || (pwrite_i && paddr_i == REG_STATUS));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_width_o  <= '0;
      cfg_height_o <= '0;
      cfg_slots_o  <= '0;
    end else if (wr_cfg) begin
      cfg_width_o  <= pwdata_i[2:0];
      cfg_height_o <= pwdata_i[11:8];
      cfg_slots_o  <= pwdata_i[19:16];
    end
  end

  // Command bits turn into single-cycle pulses after the access phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clear_o       <= 1'b0;
      pad_setup_o   <= 1'b0;
      rst_w_index_o <= 1'b0;
    end else begin
      clear_o       <= wr_cmd && pwdata_i[0];
      pad_setup_o   <= wr_cmd && pwdata_i[1];
      rst_w_index_o <= wr_cmd && pwdata_i[2];
    end
  end

  // Sticky record that a block was fully consumed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      empty_seen_q <= 1'b0;
    end else if (clear_o) begin
      empty_seen_q <= 1'b0;
    end else if (empty_i) begin
      empty_seen_q <= 1'b1;
    end
  end

  always_comb begin
    prdata_o = '0;
    if (paddr_i == REG_CFG) begin
      prdata_o[2:0]   = cfg_width_o;
      prdata_o[11:8]  = cfg_height_o;
      prdata_o[19:16] = cfg_slots_o;
    end else if (paddr_i == REG_STATUS) begin
      prdata_o[0] = full_i;
      prdata_o[1] = empty_seen_q;
      prdata_o[2] = x_valid_i;
    end
  end

endmodule

`default_nettype wire

/* xbuf_top.sv */
// Operand staging subsystem top
`timescale 1ns/10ps
`default_nettype none

module xbuf_top
  import xbuf_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [APB_AW-1:0]             paddr_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [APB_DW-1:0]             pwdata_i,
  output logic [APB_DW-1:0]             prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  input  logic                          x_load_i,
  input  logic [DW-1:0]                 x_data_i,
  input  logic                          h_shift_i,
  output logic [W-1:0][H-1:0][BITW-1:0] x_buffer_o,
  output logic                          x_valid_o,
  output logic                          full_o,
  output logic                          empty_o
);

  logic [WIDX_W-1:0] cfg_width;
  logic [CNT_W-1:0]  cfg_height;
  logic [CNT_W-1:0]  cfg_slots;
  logic              clear;
  logic              pad_setup;
  logic              rst_w_index;

  logic              pad_wr_en;
  logic [LINE_W-1:0] pad_wr_line;
  logic              pad_rd_en;
  logic [COL_W-1:0]  pad_rd_col;
  logic [W-1:0][BITW-1:0] pad_rdata;

  logic              buf_wr_en;
  logic [PTR_W-1:0]  buf_wr_slot;
  logic              buf_wr_zero;
  logic              buf_rd_bank;
  logic [W-1:0][BITW-1:0] buf_wdata;

  // Padding columns replace pad data with zeros on the way in
  assign buf_wdata = buf_wr_zero ? '0 : pad_rdata;

  xbuf_regs u_regs (
    .clk_i, .rst_ni, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .full_i       (full_o),
    .empty_i      (empty_o),
    .x_valid_i    (x_valid_o),
    .cfg_width_o  (cfg_width),
    .cfg_height_o (cfg_height),
    .cfg_slots_o  (cfg_slots),
    .clear_o      (clear),
    .pad_setup_o  (pad_setup),
    .rst_w_index_o(rst_w_index)
  );

  xbuf_ctrl u_ctrl (
    .clk_i, .rst_ni,
    .clear_i      (clear),
    .pad_setup_i  (pad_setup),
    .rst_w_index_i(rst_w_index),
    .cfg_width_i  (cfg_width),
    .cfg_height_i (cfg_height),
    .cfg_slots_i  (cfg_slots),
    .x_load_i, .h_shift_i,
    .pad_wr_en_o  (pad_wr_en),
    .pad_wr_line_o(pad_wr_line),
    .pad_rd_en_o  (pad_rd_en),
    .pad_rd_col_o (pad_rd_col),
    .buf_wr_en_o  (buf_wr_en),
    .buf_wr_slot_o(buf_wr_slot),
    .buf_wr_zero_o(buf_wr_zero),
    .buf_rd_bank_o(buf_rd_bank),
    .x_valid_o, .full_o, .empty_o
  );

  xbuf_pad_mem u_pad (
    .clk_i, .rst_ni,
    .clear_i  (clear),
    .wr_en_i  (pad_wr_en),
    .wr_line_i(pad_wr_line),
    .wdata_i  (x_data_i),
    .rd_en_i  (pad_rd_en),
    .rd_col_i (pad_rd_col),
    .rdata_o  (pad_rdata)
  );

  xbuf_row_buffer u_buf (
    .clk_i, .rst_ni,
    .clear_i  (clear),
    .wr_en_i  (buf_wr_en),
    .wr_slot_i(buf_wr_slot),
    .wdata_i  (buf_wdata),
    .rd_bank_i(buf_rd_bank),
    .rdata_o  (x_buffer_o)
  );

endmodule

`default_nettype wire

/* tb_xbuf.sv */
// Operand staging testbench
`timescale 1ns/10ps
`default_nettype none

module tb_xbuf
  import xbuf_pkg::*;
();

  // The tests need roughly 350 cycles, so a stuck wait trips this well before any hang
  localparam int MAX_CYCLES = 2000;

  logic clk = 1'b0;
  logic rst_n;
  logic [APB_AW-1:0] paddr;
  logic psel;
  logic penable;
  logic pwrite;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic pready;
  logic pslverr;
  logic x_load;
  logic [DW-1:0] x_data;
  logic h_shift;
  logic [W-1:0][H-1:0][BITW-1:0] x_buffer;
  logic x_valid;
  logic full;
  logic empty;

  // Reference copy of the pad contents, indexed by line then column
  logic [BITW-1:0] pad_model [W][TOT_DEPTH];
  logic [31:0] seed = 32'h561adc4b;
  int line_count;
  int retired;
  int cur_width;
  int cur_height;
  int cur_slots;
  int cycles = 0;
  int err_count = 0;

  xbuf_top dut (
    .clk_i(clk), .rst_ni(rst_n), .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
    .pslverr_o(pslverr), .x_load_i(x_load), .x_data_i(x_data), .h_shift_i(h_shift),
    .x_buffer_o(x_buffer), .x_valid_o(x_valid), .full_o(full), .empty_o(empty)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic exp_err);
    @(negedge clk);
    paddr = addr;
    pwdata = data;
    pwrite = 1'b1;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    check("pready_o", 32'(pready), 32'd1);
    check("pslverr_o", 32'(pslverr), 32'(exp_err));
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                          input logic exp_err);
    @(negedge clk);
    paddr = addr;
    pwrite = 1'b0;
    psel = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    check("pslverr_o", 32'(pslverr), 32'(exp_err));
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_cfg(input int width, input int height, input int slots);
    apb_write(REG_CFG, 32'((slots << 16) | (height << 8) | width), 1'b0);
    cur_width = width;
    cur_height = height;
    cur_slots = slots;
  endtask

  // Command effects land one cycle after the write, so the model follows after that edge
  task automatic send_cmd(input logic [2:0] bits);
    apb_write(REG_CMD, 32'(bits), 1'b0);
    @(negedge clk);
    if (bits[0] || bits[2]) begin
      line_count = 0;
    end
    if (bits[0] || bits[1]) begin
      retired = 0;
    end
    if (bits[0]) begin
      for (int w = 0; w < W; w++) begin
        for (int c = 0; c < TOT_DEPTH; c++) begin
          pad_model[w][c] = '0;
        end
      end
    end
  endtask

  task automatic load_row();
    logic [DW-1:0] word;
    logic [31:0] r;
    for (int e = 0; e < TOT_DEPTH; e++) begin
      r = next_rand();
      word[e*BITW +: BITW] = r[31:16];
      pad_model[line_count][e] = r[31:16];
    end
    @(negedge clk);
    x_load = 1'b1;
    x_data = word;
    @(negedge clk);
    x_load = 1'b0;
    line_count++;
    check("full_o", 32'(full), 32'(line_count == cur_width));
  endtask

  task automatic wait_valid();
    @(negedge clk);
    while (!x_valid) begin
      @(negedge clk);
    end
  endtask

  task automatic shift();
    logic exp_empty;
    wait_valid();
    exp_empty = (retired == cur_slots - 1);
    h_shift = 1'b1;
    #1;
    check("empty_o", 32'(empty), 32'(exp_empty));
    @(negedge clk);
    h_shift = 1'b0;
    retired++;
  endtask

  task automatic ignored_shift();
    check("x_valid_o", 32'(x_valid), 32'd0);
    h_shift = 1'b1;
    #1;
    check("empty_o", 32'(empty), 32'd0);
    @(negedge clk);
    h_shift = 1'b0;
  endtask

  // Bank b shows model columns b*H to b*H+H-1, transposed, zero from the height up
  task automatic check_bank(input int bank);
    int col;
    logic [BITW-1:0] exp;
    for (int w = 0; w < W; w++) begin
      for (int h = 0; h < H; h++) begin
        col = bank * H + h;
        exp = (col < cur_height) ? pad_model[w][col] : '0;
        check($sformatf("x_buffer_o[%0d][%0d]", w, h), 32'(x_buffer[w][h]), 32'(exp));
      end
    end
  endtask

  task automatic consume_block();
    logic [31:0] data;
    for (int b = 0; b < cur_slots / H; b++) begin
      wait_valid();
      check_bank(b);
      repeat (H) shift();
    end
    check("x_valid_o", 32'(x_valid), 32'd0);
    apb_read(REG_STATUS, data, 1'b0);
    check("status", data, 32'd2 | 32'(line_count == cur_width));
  endtask

  task automatic fill_and_run();
    repeat (W) load_row();
    send_cmd(3'b010);
    consume_block();
  endtask

  task automatic test_reset_regs();
    logic [31:0] data;
    check("full_o", 32'(full), 32'd0);
    check("empty_o", 32'(empty), 32'd0);
    check("x_valid_o", 32'(x_valid), 32'd0);
    apb_read(REG_STATUS, data, 1'b0);
    check("status", data, 32'd0);
    apb_write(REG_CFG, 32'hFFFF_FFFF, 1'b0);
    apb_read(REG_CFG, data, 1'b0);
    check("cfg", data, 32'h000F_0F07);
    set_cfg(4, 8, 8);
    apb_read(REG_CFG, data, 1'b0);
    check("cfg", data, 32'h0008_0804);
    apb_write(32'hC, 32'h1, 1'b1);
    apb_read(32'h10, data, 1'b1);
    apb_write(REG_STATUS, 32'h0, 1'b1);
  endtask

  task automatic test_full_flag();
    repeat (W) load_row();
    send_cmd(3'b100);
    check("full_o", 32'(full), 32'd0);
  endtask

  task automatic test_ignored_shift();
    logic [31:0] data;
    send_cmd(3'b100);
    set_cfg(4, 8, 8);
    repeat (W) load_row();
    repeat (2) ignored_shift();
    send_cmd(3'b010);
    repeat (2) ignored_shift();
    consume_block();
    repeat (4) @(negedge clk);
    apb_read(REG_STATUS, data, 1'b0);
    check("status", data, 32'd3);
    send_cmd(3'b100);
    fill_and_run();
  endtask

  task automatic test_clear();
    logic [31:0] data;
    send_cmd(3'b100);
    repeat (W) load_row();
    send_cmd(3'b010);
    wait_valid();
    check_bank(0);
    // A readable bank shows in the status word next to the sticky empty bit
    apb_read(REG_STATUS, data, 1'b0);
    check("status", data, 32'd6 | 32'(line_count == cur_width));
    repeat (2) shift();
    send_cmd(3'b001);
    check("x_valid_o", 32'(x_valid), 32'd0);
    check("full_o", 32'(full), 32'd0);
    apb_read(REG_STATUS, data, 1'b0);
    check("status", data, 32'd0);
    fill_and_run();
  endtask

  initial begin
    rst_n = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    x_load = 1'b0;
    x_data = '0;
    h_shift = 1'b0;
    line_count = 0;
    retired = 0;
    for (int w = 0; w < W; w++) begin
      for (int c = 0; c < TOT_DEPTH; c++) begin
        pad_model[w][c] = '0;
      end
    end
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    test_reset_regs();
    test_full_flag();
    fill_and_run();
    send_cmd(3'b100);
    set_cfg(4, 5, 8);
    fill_and_run();
    test_ignored_shift();
    test_clear();

    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
xbuf_pkg.sv
xbuf_pad_mem.sv
xbuf_row_buffer.sv
xbuf_ctrl.sv
xbuf_regs.sv
xbuf_top.sv
tb_xbuf.sv

/* Makefile */
SIM     := verilator
FLAGS   := --binary --timing -j 0
TOP     := tb_xbuf
FLIST   := flist.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell cat $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
